// ==== logic/iccm_bank_decode.sv ====
/*
 * ICCM bank decode
 * Per-bank enables, row indices and write lane steering
 */
`timescale 1ns/1ps
`include "iccm_settings.svh"

module iccm_bank_decode
   import iccm_mem_pkg::*;
   import iccm_req_pkg::*;
(
   input  iccm_req_t                            req,
   output iccm_bank_ctl_t [`ICCM_NUM_BANKS-1:0] bank_ctl
);

   iccm_addr_t                  addr_hi;   // Second halfword or word of the access
   logic [`ICCM_NUM_BANKS-1:0]  hit_lo;    // Bank matches the request address
   logic [`ICCM_NUM_BANKS-1:0]  hit_hi;    // Bank matches the second address
   iccm_word_t [1:0]            lane;      // Write lanes split from the double word

   // Plus 2 halfwords for a double word, plus 1 otherwise
   assign addr_hi = iccm_next_addr(req.addr, req.size);

   assign lane[0] = req.wr_data[`ICCM_WORD_BITS-1:0];
   assign lane[1] = req.wr_data[2*`ICCM_WORD_BITS-1:`ICCM_WORD_BITS];

   //**************************************************
   // Per-bank control
   //**************************************************
   always_comb begin
      for (int b = 0; b < `ICCM_NUM_BANKS; b++) begin
         hit_lo[b] = (req.addr[`ICCM_BANK_HI:2] == iccm_bank_t'(b));
         hit_hi[b] = (addr_hi[`ICCM_BANK_HI:2] == iccm_bank_t'(b));

         bank_ctl[b].en = (req.wren | req.rden) & (hit_lo[b] | hit_hi[b]);
         bank_ctl[b].we = req.wren & (hit_lo[b] | hit_hi[b]);

         // Row from whichever address hits this bank
         // Bank 0 reached through the second address lands in the next row
         if (hit_lo[b]) begin
            bank_ctl[b].index = req.addr[`ICCM_BITS-1:`ICCM_BANK_HI+1];
         end
         else begin
            bank_ctl[b].index = addr_hi[`ICCM_BITS-1:`ICCM_BANK_HI+1];
         end

         // Even banks take lane 0, odd banks lane 1
         bank_ctl[b].wdata = lane[b % 2];
      end
   end

endmodule

// ==== logic/iccm_bank_ram.sv ====
/*
 * Behavioral single port bank RAM
 * Registered read output, held while idle
 */
`timescale 1ns/1ps
`include "iccm_settings.svh"

module iccm_bank_ram
   import iccm_mem_pkg::*;
   import iccm_req_pkg::*;
(
   input  logic           clk,
   input  iccm_bank_ctl_t ctl,    // Enable, write, row, data
   output iccm_word_t     dout    // Read word, one cycle late
);

   localparam int DEPTH = 1 << `ICCM_INDEX_BITS;

   iccm_word_t mem [DEPTH];   // Check bits stored as plain data

   //**************************************************
   // Single port access
   //**************************************************
   always_ff @(posedge clk) begin
      if (ctl.en) begin
         if (ctl.we) begin
            mem[ctl.index] <= ctl.wdata;   // Write, output keeps old value
         end
         else begin
            dout <= mem[ctl.index];   // Read into output register
         end
      end
      // Idle bank holds its last read word
   end

endmodule

// ==== logic/iccm_mem.sv ====
/*
 * ICCM top level
 * Four interleaved banks, spare rows and aligned read path
 */
`timescale 1ns/1ps
`include "iccm_settings.svh"

module iccm_mem
   import iccm_mem_pkg::*;
   import iccm_req_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  iccm_req_t   req,           // One read or write per cycle
   input  iccm_fix_t   fix,           // Correction control
   output iccm_rdata_t rd_data,       // Valid one cycle after rden
   output iccm_dword_t rd_data_ecc    // Raw words, same cycle as rd_data
);

   iccm_bank_ctl_t [`ICCM_NUM_BANKS-1:0] bank_ctl;
   iccm_word_t [`ICCM_NUM_BANKS-1:0]     bank_dout;
   logic [`ICCM_NUM_BANKS-1:0]           sel0_q;
   logic [`ICCM_NUM_BANKS-1:0]           sel1_q;
   iccm_word_t [1:0]                     row_data;

   //**************************************************
   // Request decode and banks
   //**************************************************
   iccm_bank_decode iccm_bank_decode_i (
      .req      (req),
      .bank_ctl (bank_ctl)
   );

   for (genvar b = 0; b < `ICCM_NUM_BANKS; b++) begin : g_bank
      iccm_bank_ram iccm_bank_ram_i (
         .clk  (clk),
         .ctl  (bank_ctl[b]),
         .dout (bank_dout[b])
      );
   end

   // Spare rows for hard faults
   iccm_redundancy iccm_redundancy_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .fix      (fix),
      .sel0_q   (sel0_q),
      .sel1_q   (sel1_q),
      .row_data (row_data)
   );

   //**************************************************
   // Read data
   //**************************************************
   iccm_read_align iccm_read_align_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .addr        (req.addr),
      .size        (req.size),
      .bank_dout   (bank_dout),
      .sel0_q      (sel0_q),
      .sel1_q      (sel1_q),
      .row_data    (row_data),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

endmodule

// ==== logic/iccm_mem_pkg.sv ====
/*
 * Storage types of the ICCM
 * Addresses, bank numbers, row indices and stored words
 */
`include "iccm_settings.svh"

package iccm_mem_pkg;

   //**************************************************
   // Addresses
   //**************************************************
   typedef logic [`ICCM_BITS-1:1]            iccm_addr_t;       // Halfword address
   typedef logic [`ICCM_BITS-1:2]            iccm_word_addr_t;  // Word address
   typedef logic [`ICCM_BANK_BITS-1:0]       iccm_bank_t;       // Bank number
   typedef logic [`ICCM_INDEX_BITS-1:0]      iccm_index_t;      // Row inside one bank

   //**************************************************
   // Data
   //**************************************************
   typedef logic [`ICCM_WORD_BITS-1:0]       iccm_word_t;   // One word with check bits
   typedef logic [2*`ICCM_WORD_BITS-1:0]     iccm_dword_t;  // Two words, lane 1 on top

   // Aligned read data, check bits removed
   typedef logic [2*`ICCM_DATA_BITS-1:0]     iccm_rdata_t;

endpackage

// ==== logic/iccm_read_align.sv ====
/*
 * ICCM read path
 * Spare substitution, bank select and halfword alignment
 */
`timescale 1ns/1ps
`include "iccm_settings.svh"

module iccm_read_align
   import iccm_mem_pkg::*;
   import iccm_req_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  iccm_addr_t                 addr,
   input  iccm_size_e                 size,
   input  iccm_word_t [`ICCM_NUM_BANKS-1:0] bank_dout,
   input  logic [`ICCM_NUM_BANKS-1:0] sel0_q,
   input  logic [`ICCM_NUM_BANKS-1:0] sel1_q,
   input  iccm_word_t [1:0]           row_data,
   output iccm_rdata_t                rd_data,
   output iccm_dword_t                rd_data_ecc
);

   iccm_addr_t                        addr_hi;
   logic [`ICCM_BANK_HI:1]            lo_q;      // Low bank and halfword bit
   iccm_bank_t                        hi_q;      // Bank of the second address
   iccm_word_t [`ICCM_NUM_BANKS-1:0]  bank_fn;   // Bank data after spare substitution
   iccm_word_t                        lo_word;
   iccm_word_t                        hi_word;
   iccm_rdata_t                       rd_pre;

   assign addr_hi = iccm_next_addr(addr, size);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lo_q <= '0;
         hi_q <= '0;
      end
      else begin
         lo_q <= addr[`ICCM_BANK_HI:1];
         hi_q <= addr_hi[`ICCM_BANK_HI:2];
      end
   end

   //**************************************************
   // Spare rows override bank output
   //**************************************************
   always_comb begin
      for (int b = 0; b < `ICCM_NUM_BANKS; b++) begin
         if (sel1_q[b]) bank_fn[b] = row_data[1];        // Row 1 wins on double match
         else if (sel0_q[b]) bank_fn[b] = row_data[0];
         else bank_fn[b] = bank_dout[b];
      end
   end

   assign lo_word = bank_fn[lo_q[`ICCM_BANK_HI:2]];
   assign hi_word = bank_fn[hi_q];

   assign rd_pre  = {hi_word[`ICCM_DATA_BITS-1:0], lo_word[`ICCM_DATA_BITS-1:0]};
   assign rd_data = lo_q[1] ? (rd_pre >> 16) : rd_pre;   // Odd halfword, top 16 zero
   assign rd_data_ecc = {hi_word, lo_word};               // Raw words with check bits

endmodule

// ==== logic/iccm_redundancy.sv ====
/*
 * ICCM redundancy for hard faults
 * Two spare rows with address match, LRU replacement and write update
 */
`timescale 1ns/1ps
`include "iccm_settings.svh"

module iccm_redundancy
   import iccm_mem_pkg::*;
   import iccm_req_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  iccm_req_t                  req,
   input  iccm_fix_t                  fix,
   output logic [`ICCM_NUM_BANKS-1:0] sel0_q,     // Spare row 0 replaces bank, read cycle
   output logic [`ICCM_NUM_BANKS-1:0] sel1_q,     // Spare row 1 replaces bank, read cycle
   output iccm_word_t [1:0]           row_data    // Spare data copies
);

   iccm_addr_t                       addr_hi;     // Second address of the access
   iccm_word_addr_t [1:0]            row_addr;    // Word address held by each spare row
   logic [1:0]                       row_valid;
   logic                             lru;         // Row replaced by the next correction
   logic [1:0][`ICCM_NUM_BANKS-1:0]  sel;         // Per row, per bank address match
   logic [1:0]                       load;        // Correction fills this row
   logic [1:0]                       wr_hit;      // Write touches this row's word
   logic [1:0]                       data_en;
   iccm_word_t [1:0]                 data_in;
   iccm_word_t [1:0]                 lane;
   logic                             rd_hit;      // Read hit while correcting

   assign addr_hi = iccm_next_addr(req.addr, req.size);

   assign lane[0] = req.wr_data[`ICCM_WORD_BITS-1:0];
   assign lane[1] = req.wr_data[2*`ICCM_WORD_BITS-1:`ICCM_WORD_BITS];

   //**************************************************
   // Address match per row and bank
   //**************************************************
   always_comb begin
      for (int r = 0; r < 2; r++) begin
         for (int b = 0; b < `ICCM_NUM_BANKS; b++) begin
            sel[r][b] = row_valid[r] &
                        (((req.addr[`ICCM_BITS-1:2] == row_addr[r]) &
                          (req.addr[`ICCM_BANK_HI:2] == iccm_bank_t'(b))) |
                         ((addr_hi[`ICCM_BITS-1:2] == row_addr[r]) &
                          (addr_hi[`ICCM_BANK_HI:2] == iccm_bank_t'(b))));
         end
      end
   end

   //**************************************************
   // Spare row update
   //**************************************************
   always_comb begin
      for (int r = 0; r < 2; r++) begin
         load[r] = fix.correct_ecc & (lru == r[0]);   // LRU 0 picks row 0

         // Double word also covers the word at the second address
         wr_hit[r] = req.wren & row_valid[r] &
                     ((req.addr[`ICCM_BITS-1:2] == row_addr[r]) |
                      ((req.size == size_d) & (addr_hi[`ICCM_BITS-1:2] == row_addr[r])));

         data_en[r] = load[r] | wr_hit[r];

         // Correction data is splat, take the low lane
         // A write lands on the lane of the row's bank parity
         if (load[r]) begin
            data_in[r] = lane[0];
         end
         else begin
            data_in[r] = lane[row_addr[r][2]];
         end
      end
   end

   assign rd_hit = req.rden & fix.correction_state & ((|sel[0]) | (|sel[1]));

   // Control state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         row_valid <= '0;
         lru       <= 1'b0;
         sel0_q    <= '0;
         sel1_q    <= '0;
      end
      else begin
         for (int r = 0; r < 2; r++) begin
            if (load[r]) row_valid[r] <= 1'b1;
         end
         if (fix.correct_ecc) begin
            lru <= ~lru;              // Next correction uses the other row
         end
         else if (rd_hit) begin
            lru <= |sel[0];           // Protect the row just hit
         end
         sel0_q <= sel[0];
         sel1_q <= sel[1];
      end
   end

   // Spare addresses and copies
   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (load[r]) row_addr[r] <= req.addr[`ICCM_BITS-1:2];
         if (data_en[r]) row_data[r] <= data_in[r];
      end
   end

endmodule

// ==== logic/iccm_req_pkg.sv ====
/*
 * Request side types of the ICCM
 * Write size, request, correction and per-bank control
 */
package iccm_req_pkg;
   import iccm_mem_pkg::*;

   typedef enum logic [1:0] {
      size_b = 2'b00,
      size_h = 2'b01,
      size_w = 2'b10,
      size_d = 2'b11   // Double word, spans two banks
   } iccm_size_e;

   typedef struct packed {
      logic        wren;
      logic        rden;
      iccm_addr_t  addr;      // Halfword aligned
      iccm_size_e  size;
      iccm_dword_t wr_data;   // Lane 0 low, lane 1 high
   } iccm_req_t;

   typedef struct packed {
      logic correct_ecc;        // Single bit error correct cycle
      logic correction_state;   // Correction in progress
   } iccm_fix_t;

   typedef struct packed {
      logic        en;
      logic        we;
      iccm_index_t index;
      iccm_word_t  wdata;
   } iccm_bank_ctl_t;

   // Address of the second bank touched by an access
   function automatic iccm_addr_t iccm_next_addr(input iccm_addr_t addr, input iccm_size_e size);
      return addr + ((size == size_d) ? iccm_addr_t'(2) : iccm_addr_t'(1));
   endfunction

endpackage

// ==== logic/iccm_settings.svh ====
/*
 * ICCM geometry macros
 * Address width, bank layout and stored word widths
 */
`ifndef ICCM_SETTINGS_SVH
`define ICCM_SETTINGS_SVH

//**************************************************
// Address map
//**************************************************
`define ICCM_BITS        12   // Byte address width
`define ICCM_NUM_BANKS   4    // Word interleaved banks
`define ICCM_BANK_BITS   2    // Bank select width
`define ICCM_BANK_HI     3    // Bank select at addr[3:2]
`define ICCM_INDEX_BITS  8    // Row index at addr[11:4]

//**************************************************
// Word layout
//**************************************************
`define ICCM_WORD_BITS   39   // 32 data + 7 check bits
`define ICCM_DATA_BITS   32   // Data part only

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build the ICCM testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module iccm_tb -f sources.f > build.log 2>&1 &&
   ./obj_dir/Viccm_tb > sim.log 2>&1 ||
   echo "Build or simulation exited with an error"

grep -q "Regression passed" sim.log && echo "PASS" && exit 0 ||
   { echo "FAIL, see sim.log and build.log"; exit 1; }

// ==== sources.f ====
+incdir+logic
+incdir+tb
logic/iccm_mem_pkg.sv
logic/iccm_req_pkg.sv
logic/iccm_bank_ram.sv
logic/iccm_bank_decode.sv
logic/iccm_redundancy.sv
logic/iccm_read_align.sv
logic/iccm_mem.sv
tb/iccm_tb.sv

// ==== tb/iccm_ref.svh ====
/*
 * ICCM reference model
 * Shadow banks, spare rows, LRU bit and expected read data
 */
`ifndef ICCM_REF_SVH
`define ICCM_REF_SVH

typedef struct packed {
   iccm_rdata_t data;   // Aligned read data
   iccm_dword_t ecc;    // Raw words, upper on top
} rd_exp_t;

iccm_word_t      ref_bank [`ICCM_NUM_BANKS][1 << `ICCM_INDEX_BITS];
iccm_word_addr_t ref_row_addr [2];
logic            ref_row_valid [2];
iccm_word_t      ref_row_data [2];
logic            ref_lru;   // Row taken by the next correction

function automatic void ref_reset();
   for (int r = 0; r < 2; r++) begin
      ref_row_valid[r] = 1'b0;
      ref_row_addr[r]  = '0;
      ref_row_data[r]  = '0;
   end
   ref_lru = 1'b0;
endfunction

// Word as seen by a read, spare copy first
function automatic iccm_word_t ref_lookup(input iccm_word_addr_t w);
   iccm_word_t v;
   v = ref_bank[w[3:2]][w[11:4]];   // Bank from addr[3:2], row from addr[11:4]
   if (ref_row_valid[0] && ref_row_addr[0] == w) v = ref_row_data[0];
   if (ref_row_valid[1] && ref_row_addr[1] == w) v = ref_row_data[1];   // Row 1 wins
   return v;
endfunction

function automatic void ref_apply(input iccm_req_t rq, input iccm_fix_t fx);
   iccm_addr_t      a_hi;
   iccm_word_addr_t w0;
   iccm_word_addr_t w1;
   iccm_word_t      lane [2];
   logic [1:0]      wr_hit;
   logic [1:0]      rd_hit;
   a_hi    = rq.addr + ((rq.size == size_d) ? iccm_addr_t'(2) : iccm_addr_t'(1));
   w0      = rq.addr[`ICCM_BITS-1:2];
   w1      = a_hi[`ICCM_BITS-1:2];   // Same word unless double word
   lane[0] = rq.wr_data[`ICCM_WORD_BITS-1:0];
   lane[1] = rq.wr_data[2*`ICCM_WORD_BITS-1:`ICCM_WORD_BITS];
   // Matches against the rows as they were before this cycle
   for (int r = 0; r < 2; r++) begin
      wr_hit[r] = rq.wren && ref_row_valid[r] &&
                  (ref_row_addr[r] == w0 || (rq.size == size_d && ref_row_addr[r] == w1));
      rd_hit[r] = ref_row_valid[r] && (ref_row_addr[r] == w0 || ref_row_addr[r] == w1);
   end
   if (rq.wren) begin
      ref_bank[w0[3:2]][w0[11:4]] = lane[w0[2]];   // Even bank lane 0, odd bank lane 1
      ref_bank[w1[3:2]][w1[11:4]] = lane[w1[2]];
   end
   for (int r = 0; r < 2; r++) begin
      if (wr_hit[r]) ref_row_data[r] = lane[ref_row_addr[r][2]];
   end
   if (fx.correct_ecc) begin
      ref_row_addr[ref_lru]  = w0;
      ref_row_valid[ref_lru] = 1'b1;
      ref_row_data[ref_lru]  = lane[0];   // Beats a write hit on the same row
      ref_lru                = ~ref_lru;
   end
   else if (rq.rden && fx.correction_state && (|rd_hit)) begin
      ref_lru = rd_hit[0];   // Keep the row just hit
   end
endfunction

function automatic rd_exp_t expected_read(input iccm_addr_t a);
   iccm_word_addr_t w_lo;
   iccm_word_t      lo;
   iccm_word_t      hi;
   rd_exp_t         e;
   w_lo   = a[`ICCM_BITS-1:2];
   lo     = ref_lookup(w_lo);
   hi     = ref_lookup(w_lo + iccm_word_addr_t'(1));   // Wraps bank 3 to bank 0, next row
   e.ecc  = {hi, lo};
   e.data = {hi[`ICCM_DATA_BITS-1:0], lo[`ICCM_DATA_BITS-1:0]};
   if (a[1]) e.data = e.data >> 16;   // Odd halfword
   return e;
endfunction

`endif

// ==== tb/iccm_tb.sv ====
/*
 * ICCM testbench
 * Writes, aligned reads and spare row corrections against a reference model
 */
`timescale 1ns/1ps
`include "iccm_settings.svh"

module iccm_tb
   import iccm_mem_pkg::*;
   import iccm_req_pkg::*;
();

   logic        clk;
   logic        rst_n;
   iccm_req_t   req;
   iccm_fix_t   fix;
   iccm_rdata_t rd_data;
   iccm_dword_t rd_data_ecc;

   `include "iccm_ref.svh"

   integer  seed;
   int      n_checks;
   int      n_errors;
   int      test_checks;   // Counts when the running test began
   int      test_errors;
   logic    cur_valid;     // Read data due at this falling edge
   rd_exp_t cur_exp;
   rd_exp_t exp_q [$];     // One entry per issued read

   initial clk = 1'b0;
   always #10 clk = ~clk;   // 20 ns period

   iccm_mem iccm_mem_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .fix         (fix),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

   //**************************************************
   // Stimulus helpers
   //**************************************************
   task automatic drive(input iccm_req_t rq, input iccm_fix_t fx);
      @(negedge clk);
      req = rq;
      fix = fx;
      if (rq.rden) exp_q.push_back(expected_read(rq.addr));   // State before this cycle
      ref_apply(rq, fx);
   endtask

   task automatic write_mem(input iccm_word_addr_t w, input iccm_size_e sz, input iccm_dword_t d);
      drive('{wren: 1'b1, rden: 1'b0, addr: {w, 1'b0}, size: sz, wr_data: d}, '0);
   endtask

   task automatic read_mem(input iccm_addr_t a);
      drive('{wren: 1'b0, rden: 1'b1, addr: a, size: size_d, wr_data: '0}, '0);
   endtask

   // Correction cycle only with data splat on both lanes
   task automatic correct_word(input iccm_word_addr_t w, input iccm_word_t d);
      drive('{wren: 1'b0, rden: 1'b0, addr: {w, 1'b0}, size: size_w, wr_data: {d, d}},
            '{correct_ecc: 1'b1, correction_state: 1'b0});
   endtask

   task automatic finish_test(input string name);
      int cnt;
      cnt = 0;
      drive('0, '0);
      while ((exp_q.size() != 0 || cur_valid) && cnt < 20) begin
         @(negedge clk);
         cnt++;
      end
      if (exp_q.size() != 0 || cur_valid) begin
         $display("Timeout: read data still pending after %0d cycles", cnt);
         n_errors++;
      end
      $display("%-32s checks %0d errors %0d", name, n_checks - test_checks,
               n_errors - test_errors);
      test_checks = n_checks;
      test_errors = n_errors;
   endtask

   function automatic iccm_word_t rand_word();
      logic [31:0] lo;
      logic [31:0] hi;
      lo = $random(seed);
      hi = $random(seed);
      return {hi[6:0], lo};
   endfunction

   // Fill data uses every address bit
   function automatic iccm_word_t fill_word(input iccm_word_addr_t w);
      return {w[8:2] ^ 7'h35, 32'h9e370000 ^ {w, 6'h00, ~w, 6'h00}};
   endfunction

   //**************************************************
   // Read data capture and compare
   //**************************************************
   always @(posedge clk) begin
      if (rst_n && req.rden) begin
         if (exp_q.size() > 0) begin
            cur_exp   <= exp_q.pop_front();
            cur_valid <= 1'b1;
         end
         else begin
            $display("Read issued with no expected value queued");
            n_errors++;
            cur_valid <= 1'b0;
         end
      end
      else begin
         cur_valid <= 1'b0;
      end
   end

   always @(negedge clk) begin
      if (cur_valid) begin
         n_checks += 2;
         if (rd_data !== cur_exp.data) begin
            $display("** Error: rd_data = %h, expected %h", rd_data, cur_exp.data);
            n_errors++;
         end
         if (rd_data_ecc !== cur_exp.ecc) begin
            $display("** Error: rd_data_ecc = %h, expected %h", rd_data_ecc, cur_exp.ecc);
            n_errors++;
         end
      end
   end

   //**************************************************
   // Test sequence
   //**************************************************
   initial begin
      iccm_word_addr_t ws [8];
      iccm_word_t      d;
      seed        = 32'hc2976360;
      n_checks    = 0;
      n_errors    = 0;
      test_checks = 0;
      test_errors = 0;
      cur_valid   = 1'b0;
      rst_n       = 1'b0;
      req         = '0;
      fix         = '0;
      ref_reset();
      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      // Known contents everywhere
      for (int i = 0; i < 1024; i += 2) begin
         write_mem(iccm_word_addr_t'(i), size_d,
                   {fill_word(iccm_word_addr_t'(i + 1)), fill_word(iccm_word_addr_t'(i))});
      end

      for (int i = 0; i < 8; i++) begin
         ws[i] = iccm_word_addr_t'($random(seed));
         write_mem(ws[i], size_d, {rand_word(), rand_word()});
      end
      for (int i = 0; i < 8; i++) read_mem({ws[i], 1'b0});
      finish_test("double word write and read");

      for (int i = 0; i < 8; i++) begin
         ws[i] = iccm_word_addr_t'($random(seed));
         if (i < 2) ws[i][3:2] = 2'b11;   // Bank 3 so the read wraps to bank 0
         d = rand_word();
         write_mem(ws[i], size_w, {d, d});
      end
      for (int i = 0; i < 8; i++) read_mem({ws[i], 1'b1});
      finish_test("word write, odd halfword read");

      ws[0] = iccm_word_addr_t'($random(seed));
      correct_word(ws[0], rand_word());
      read_mem({ws[0], 1'b0});
      read_mem({ws[0] - iccm_word_addr_t'(1), 1'b0});   // Neighbor below with spare on top
      read_mem({ws[0] + iccm_word_addr_t'(1), 1'b0});
      read_mem({ws[0], 1'b1});
      finish_test("correction without write");

      d = rand_word();
      write_mem(ws[0], size_w, {d, d});
      read_mem({ws[0], 1'b0});
      // Upper word hit
      write_mem(ws[0] - iccm_word_addr_t'(1), size_d, {rand_word(), rand_word()});
      read_mem({ws[0] - iccm_word_addr_t'(1), 1'b0});
      finish_test("write to corrected word");

      for (int i = 1; i < 4; i++) begin
         ws[i] = ws[0] + iccm_word_addr_t'(8 * i);
         correct_word(ws[i], rand_word());
      end
      for (int i = 0; i < 4; i++) read_mem({ws[i], 1'b0});
      finish_test("spare row replacement");

      // Row 0 hit while correcting protects that row from the next load
      drive('{wren: 1'b0, rden: 1'b1, addr: {ws[2], 1'b0}, size: size_d, wr_data: '0},
            '{correct_ecc: 1'b0, correction_state: 1'b1});
      ws[4] = ws[0] + iccm_word_addr_t'(40);
      correct_word(ws[4], rand_word());
      for (int i = 2; i < 5; i++) read_mem({ws[i], 1'b0});
      finish_test("read hit during correction");

      $display("Total checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0 && n_checks > 0) begin
         $display("Regression passed");
      end
      else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
